// ==== mipsCore.f ====
hdl/mipsPkg.sv
hdl/controlUnit.sv
hdl/pcUnit.sv
hdl/registerFile.sv
hdl/aluStage.sv
hdl/singleCycleMips.sv
verification/tbClock.sv
verification/tbMemories.sv
verification/singleCycleMipsTb.sv

// ==== Makefile ====
# Verilator build and run for the single-cycle MIPS core

SIM      ?= verilator
TOP      ?= singleCycleMipsTb
FILELIST ?= mipsCore.f
BUILD    ?= obj_dir
LOG      ?= sim.log
VFLAGS   ?= --binary --timing --assert -j 0

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(BUILD)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

# the log decides the result
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Result: FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/singleCycleMipsTb.sv ====
// ========================================
// singleCycleMipsTb
// builds a program, runs it on the core
// and checks every retiring instruction
// against an instruction-set model
// ========================================
`timescale 1ns/1ps
`default_nettype none

module singleCycleMipsTb;

  logic              clk;
  logic              rst;
  mipsPkg::word_t    instr;
  mipsPkg::word_t    instrAddr;
  mipsPkg::dmemReq_t dmemReq;
  mipsPkg::word_t    dmemRdata;
  mipsPkg::retire_t  retire;

  // program image shared with the model
  mipsPkg::word_t prog [256];
  int             progLen;
  // model state
  mipsPkg::word_t modelPc;
  mipsPkg::word_t modelRegs [32];
  mipsPkg::word_t modelMem [128];
  // pc at which each behavior is complete
  mipsPkg::word_t testEnd [6];
  string testName [6] = '{"reset", "alu", "memory", "branch", "jump", "unknown opcode"};
  int   errCount;
  int   lastErr;
  int   passCount;
  int   failCount;
  logic timedOut;

  tbClock i_clock (
    .clk (clk),
    .rst (rst)
  );

  tbMemories i_mem (
    .clk       (clk),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dmemReq   (dmemReq),
    .dmemRdata (dmemRdata)
  );

  singleCycleMips i_dut (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .instrAddr (instrAddr),
    .dmemReq   (dmemReq),
    .dmemRdata (dmemRdata),
    .retire    (retire)
  );

  // ========================================
  // program builder
  // ========================================
  function automatic mipsPkg::word_t encodeR(logic [5:0] fn, mipsPkg::regAddr_t rd,
                                             mipsPkg::regAddr_t rs, mipsPkg::regAddr_t rt);
    return {mipsPkg::opRtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic mipsPkg::word_t encodeI(logic [5:0] op, mipsPkg::regAddr_t rt,
                                             mipsPkg::regAddr_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic mipsPkg::word_t encodeJ(logic [5:0] op, int wordIdx);
    return {op, wordIdx[25:0]};
  endfunction

  function automatic mipsPkg::word_t pcOf(int wordIdx);
    return {wordIdx[29:0], 2'b00};
  endfunction

  task automatic emit(mipsPkg::word_t w);
    prog[progLen[7:0]] = w;
    progLen++;
  endtask

  task automatic buildProgram();
    mipsPkg::word_t aluOps [6];
    mipsPkg::word_t poison;
    mipsPkg::word_t tmp;
    int j;
    int loopTop;
    poison = encodeI(mipsPkg::opAddi, 5'd23, 5'd0, 16'h7bad);
    for (int i = 0; i < 256; i++) begin
      prog[i[7:0]] = '0;
    end
    progLen = 0;
    // registers are still zero here
    emit(encodeR(mipsPkg::fnOr, 5'd5, 5'd6, 5'd7));
    testEnd[0] = pcOf(progLen);
    // odd operands keep r1 nonzero
    for (int i = 1; i <= 4; i++) begin
      emit(encodeI(mipsPkg::opAddi, i[4:0], 5'd0, 16'($urandom()) | 16'd1));
    end
    aluOps[0] = encodeR(mipsPkg::fnAdd, 5'd8, 5'd1, 5'd2);
    aluOps[1] = encodeR(mipsPkg::fnSub, 5'd9, 5'd1, 5'd3);
    aluOps[2] = encodeR(mipsPkg::fnAnd, 5'd10, 5'd2, 5'd4);
    aluOps[3] = encodeR(mipsPkg::fnOr, 5'd11, 5'd3, 5'd4);
    aluOps[4] = encodeR(mipsPkg::fnSlt, 5'd12, 5'd1, 5'd2);
    aluOps[5] = encodeR(mipsPkg::fnSlt, 5'd13, 5'd4, 5'd3);
    // shuffle
    for (int i = 5; i > 0; i--) begin
      j = int'($urandom() % (i + 1));
      tmp = aluOps[i[2:0]];
      aluOps[i[2:0]] = aluOps[j[2:0]];
      aluOps[j[2:0]] = tmp;
    end
    for (int i = 0; i < 6; i++) begin
      emit(aluOps[i[2:0]]);
    end
    // write to r0 and read it back
    emit(encodeR(mipsPkg::fnOr, 5'd0, 5'd1, 5'd2));
    emit(encodeR(mipsPkg::fnOr, 5'd14, 5'd0, 5'd0));
    testEnd[1] = pcOf(progLen);
    // random word-aligned base in the sram
    tmp = {23'd0, 7'($urandom()), 2'b00};
    emit(encodeI(mipsPkg::opAddi, 5'd15, 5'd0, tmp[15:0]));
    emit(encodeI(mipsPkg::opSw, 5'd8, 5'd15, 16'd0));
    emit(encodeI(mipsPkg::opSw, 5'd9, 5'd15, 16'd4));
    emit(encodeI(mipsPkg::opLw, 5'd16, 5'd15, 16'd0));
    emit(encodeI(mipsPkg::opLw, 5'd17, 5'd15, 16'd4));
    // 64 words away in untouched fill pattern
    emit(encodeI(mipsPkg::opLw, 5'd18, 5'd15, 16'h0100));
    testEnd[2] = pcOf(progLen);
    // forward taken over two poison words
    emit(encodeI(mipsPkg::opBeq, 5'd1, 5'd1, 16'd2));
    emit(poison);
    emit(poison);
    emit(encodeI(mipsPkg::opAddi, 5'd21, 5'd0, 16'd0));
    emit(encodeI(mipsPkg::opAddi, 5'd22, 5'd0, 16'd2));
    loopTop = progLen;
    emit(encodeI(mipsPkg::opAddi, 5'd21, 5'd21, 16'd1));
    // not taken on the first pass
    emit(encodeI(mipsPkg::opBeq, 5'd21, 5'd22, 16'd1));
    // backward offset counts from pc+4
    emit(encodeI(mipsPkg::opBeq, 5'd0, 5'd0, 16'(loopTop - (progLen + 1))));
    testEnd[3] = pcOf(progLen);
    emit(encodeJ(mipsPkg::opJ, progLen + 2));
    emit(poison);
    // subroutine lives at word 48
    emit(encodeJ(mipsPkg::opJal, 48));
    testEnd[4] = pcOf(progLen);
    prog[48] = encodeI(mipsPkg::opAddi, 5'd24, 5'd31, 16'd0);
    prog[49] = encodeR(mipsPkg::fnJr, 5'd0, 5'd31, 5'd0);
    // opcodes outside the subset including lb
    emit({6'b111111, 26'($urandom())});
    emit({6'b100000, 26'($urandom())});
    // sll is an unknown funct
    emit(encodeR(6'b000000, 5'd25, 5'd1, 5'd2));
    testEnd[5] = pcOf(progLen);
    // park
    emit(encodeJ(mipsPkg::opJ, progLen));
  endtask

  task automatic loadProgram();
    for (int i = 0; i < 256; i++) begin
      i_mem.writeRom(i[7:0], prog[i[7:0]]);
    end
    for (int i = 0; i < 32; i++) begin
      modelRegs[i[4:0]] = '0;
    end
    for (int i = 0; i < 128; i++) begin
      modelMem[i[6:0]] = i_mem.fillWord(i[6:0]);
    end
    modelPc = mipsPkg::resetPc;
  endtask

  // ========================================
  // checks
  // ========================================
  task automatic reportWord(string what, mipsPkg::word_t got, mipsPkg::word_t exp);
    errCount++;
    $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic checkReset();
    assert (retire.valid == 1'b0)
      else reportWord("retire.valid in reset", {31'd0, retire.valid}, 32'd0);
    assert (instrAddr == mipsPkg::resetPc)
      else reportWord("instrAddr in reset", instrAddr, mipsPkg::resetPc);
    assert (dmemReq.cen && dmemReq.wen)
      else reportWord("cen,wen in reset", {30'd0, dmemReq.cen, dmemReq.wen}, 32'd3);
  endtask

  // one instruction by the ISA rules is compared and then committed
  task automatic checkAndStep();
    mipsPkg::word_t    ir;
    mipsPkg::word_t    rsV;
    mipsPkg::word_t    rtV;
    mipsPkg::word_t    immV;
    mipsPkg::word_t    pc4;
    mipsPkg::word_t    nextPc;
    mipsPkg::word_t    addrV;
    mipsPkg::word_t    wrData;
    mipsPkg::regAddr_t wrReg;
    logic              wrEn;
    logic              expCen;
    logic              expWen;
    ir = prog[modelPc[9:2]];
    rsV = modelRegs[ir[25:21]];
    rtV = modelRegs[ir[20:16]];
    immV = {{16{ir[15]}}, ir[15:0]};
    pc4 = modelPc + 32'd4;
    nextPc = pc4;
    addrV = rsV + immV;
    wrData = addrV;
    wrReg = ir[20:16];
    wrEn = 1'b0;
    expCen = 1'b1;
    expWen = 1'b1;
    case (ir[31:26])
      mipsPkg::opRtype: begin
        wrReg = ir[15:11];
        wrEn = 1'b1;
        case (ir[5:0])
          mipsPkg::fnAdd: wrData = rsV + rtV;
          mipsPkg::fnSub: wrData = rsV - rtV;
          mipsPkg::fnAnd: wrData = rsV & rtV;
          mipsPkg::fnOr:  wrData = rsV | rtV;
          mipsPkg::fnSlt: wrData = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
          mipsPkg::fnJr: begin
            wrEn = 1'b0;
            nextPc = rsV;
          end
          default: wrEn = 1'b0;
        endcase
      end
      mipsPkg::opAddi: wrEn = 1'b1;
      mipsPkg::opLw: begin
        wrEn = 1'b1;
        expCen = 1'b0;
        wrData = modelMem[addrV[8:2]];
      end
      mipsPkg::opSw: begin
        expCen = 1'b0;
        expWen = 1'b0;
      end
      mipsPkg::opBeq: begin
        if (rsV == rtV) begin
          nextPc = pc4 + {immV[29:0], 2'b00};
        end
      end
      mipsPkg::opJ: nextPc = {pc4[31:28], ir[25:0], 2'b00};
      mipsPkg::opJal: begin
        nextPc = {pc4[31:28], ir[25:0], 2'b00};
        wrEn = 1'b1;
        wrReg = 5'd31;
        wrData = pc4;
      end
      default: wrEn = 1'b0;
    endcase
    // r0 never takes a write
    if (wrReg == 5'd0) begin
      wrEn = 1'b0;
    end
    assert (instrAddr == modelPc) else reportWord("instrAddr", instrAddr, modelPc);
    assert (retire.valid == 1'b1)
      else reportWord("retire.valid", {31'd0, retire.valid}, 32'd1);
    assert (retire.pc == modelPc) else reportWord("retire.pc", retire.pc, modelPc);
    assert (retire.regWrite == wrEn)
      else reportWord("retire.regWrite", {31'd0, retire.regWrite}, {31'd0, wrEn});
    if (wrEn) begin
      assert (retire.regAddr == wrReg)
        else reportWord("retire.regAddr", {27'd0, retire.regAddr}, {27'd0, wrReg});
      assert (retire.regData == wrData)
        else reportWord("retire.regData", retire.regData, wrData);
    end
    assert (dmemReq.cen == expCen)
      else reportWord("dmemReq.cen", {31'd0, dmemReq.cen}, {31'd0, expCen});
    assert (dmemReq.wen == expWen)
      else reportWord("dmemReq.wen", {31'd0, dmemReq.wen}, {31'd0, expWen});
    if (!expCen) begin
      assert (dmemReq.addr == addrV[8:2])
        else reportWord("dmemReq.addr", {25'd0, dmemReq.addr}, {25'd0, addrV[8:2]});
    end
    if (!expWen) begin
      assert (dmemReq.wdata == rtV) else reportWord("dmemReq.wdata", dmemReq.wdata, rtV);
      modelMem[addrV[8:2]] = rtV;
    end
    if (wrEn) begin
      modelRegs[wrReg] = wrData;
    end
    modelPc = nextPc;
  endtask

  // outputs are settled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      checkReset();
    end else begin
      checkAndStep();
    end
  end

  // ========================================
  // sequencing
  // ========================================
  task automatic waitForReset();
    int cycles;
    cycles = 0;
    while (!rst && cycles < 20) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!rst) begin
      timedOut = 1'b1;
      $display("timeout waiting for reset release after %0d cycles", cycles);
    end
  endtask

  task automatic waitForPc(mipsPkg::word_t target);
    int cycles;
    cycles = 0;
    while (instrAddr != target && cycles < 200) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (instrAddr != target) begin
      timedOut = 1'b1;
      $display("timeout waiting for PC %h after %0d cycles", target, cycles);
    end
  endtask

  task automatic runTest(string name, mipsPkg::word_t endPc);
    int newErr;
    waitForPc(endPc);
    newErr = errCount - lastErr;
    lastErr = errCount;
    if (timedOut || newErr != 0) begin
      failCount++;
      $display("test %s: failed with %0d errors", name, newErr);
    end else begin
      passCount++;
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    errCount = 0;
    lastErr = 0;
    passCount = 0;
    failCount = 0;
    timedOut = 1'b0;
    void'($urandom(32'h0cf7e2f7));
    buildProgram();
    loadProgram();
    waitForReset();
    for (int t = 0; t < 6; t++) begin
      if (!timedOut) begin
        runTest(testName[t[2:0]], testEnd[t[2:0]]);
      end
    end
    $display("tests passed %0d, failed %0d, check errors %0d", passCount, failCount, errCount);
    if (failCount == 0 && errCount == 0 && !timedOut) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/tbMemories.sv ====
// ========================================
// tbMemories
// behavioral instruction ROM, loaded by
// the testbench, and a 128-word data SRAM
// with async read and clocked write
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tbMemories (
  input  wire                    clk,
  input  wire mipsPkg::word_t    instrAddr,
  output mipsPkg::word_t         instr,
  input  wire mipsPkg::dmemReq_t dmemReq,
  output mipsPkg::word_t         dmemRdata
);

  // 256-word rom, 128-word sram
  mipsPkg::word_t rom [256];
  mipsPkg::word_t sram [128];

  // power-up content, every address bit shows up in the word
  function automatic mipsPkg::word_t fillWord(mipsPkg::memAddr_t addr);
    return {addr, ~addr, addr, ~addr, 4'ha} ^ 32'h3c96_0f5a;
  endfunction

  // program load from the testbench top
  task automatic writeRom(logic [7:0] idx, mipsPkg::word_t w);
    rom[idx] = w;
  endtask

  initial begin
    for (int i = 0; i < 128; i++) begin
      sram[i[6:0]] = fillWord(i[6:0]);
    end
  end

  // ========================================
  // ports
  // ========================================
  // fetch ignores the byte offset
  assign instr = rom[instrAddr[9:2]];

  // async read of the addressed word
  assign dmemRdata = sram[dmemReq.addr];

  // write needs chip and write enable both low
  always @(posedge clk) begin
    if (!dmemReq.cen && !dmemReq.wen) begin
      sram[dmemReq.addr] = dmemReq.wdata;
    end
  end

endmodule

`default_nettype wire

// ==== verification/tbClock.sv ====
// ========================================
// tbClock
// 8 ns testbench clock and a reset held
// low for the first three cycles
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // release 1 ns after the third rising edge
  initial begin
    rst = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b1;
  end

endmodule

`default_nettype wire

// ==== hdl/singleCycleMips.sv ====
// ========================================
// singleCycleMips
// single-cycle core top: decode, pc,
// register file and ALU wired to the fetch
// port, the data sram and the trace
// ========================================
`timescale 1ns/1ps
`default_nettype none

module singleCycleMips (
  input  wire                    clk,
  input  wire                    rst,
  input  wire mipsPkg::word_t    instr,
  output mipsPkg::word_t         instrAddr,
  output mipsPkg::dmemReq_t      dmemReq,
  input  wire mipsPkg::word_t    dmemRdata,
  output mipsPkg::retire_t       retire
);

  mipsPkg::ctrl_t   ctrl;
  mipsPkg::aluOp_e  aluOp;
  mipsPkg::word_t   pc;
  mipsPkg::word_t   pcPlus4;
  mipsPkg::word_t   rsData;
  mipsPkg::word_t   rtData;
  mipsPkg::word_t   aluResult;
  logic             aluZero;
  mipsPkg::retire_t rfRetire;

  // ========================================
  // blocks
  // ========================================
  controlUnit i_control (
    .instr (instr),
    .ctrl  (ctrl),
    .aluOp (aluOp)
  );

  pcUnit i_pc (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .instr   (instr),
    .aluZero (aluZero),
    .rsData  (rsData),
    .pc      (pc),
    .pcPlus4 (pcPlus4)
  );

  registerFile i_regFile (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .instr     (instr),
    .aluResult (aluResult),
    .dmemRdata (dmemRdata),
    .pcPlus4   (pcPlus4),
    .rsData    (rsData),
    .rtData    (rtData),
    .retire    (rfRetire)
  );

  aluStage i_alu (
    .ctrl      (ctrl),
    .aluOp     (aluOp),
    .instr     (instr),
    .rsData    (rsData),
    .rtData    (rtData),
    .aluResult (aluResult),
    .aluZero   (aluZero),
    .dmemReq   (dmemReq)
  );

  // fetch address is the pc
  assign instrAddr = pc;

  // trace takes its pc from the pc unit
  always_comb begin
    retire    = rfRetire;
    retire.pc = pc;
  end

endmodule

`default_nettype wire

// ==== hdl/aluStage.sv ====
// ========================================
// aluStage
// immediate extension, operand select,
// ALU, zero flag and the sram request
// ========================================
`timescale 1ns/1ps
`default_nettype none

module aluStage (
  input  wire mipsPkg::ctrl_t  ctrl,
  input  wire mipsPkg::aluOp_e aluOp,
  input  wire mipsPkg::word_t  instr,
  input  wire mipsPkg::word_t  rsData,
  input  wire mipsPkg::word_t  rtData,
  output mipsPkg::word_t       aluResult,
  output logic                 aluZero,
  output mipsPkg::dmemReq_t    dmemReq
);

  mipsPkg::word_t immExt;
  mipsPkg::word_t opA;
  mipsPkg::word_t opB;

  // ========================================
  // operands
  // ========================================
  // sign-extend imm16
  assign immExt = {{16{instr[15]}}, instr[15:0]};

  assign opA = rsData;
  // addi, lw, sw take the immediate
  assign opB = ctrl.aluSrcImm ? immExt : rtData;

  // ========================================
  // alu
  // ========================================
  always_comb begin
    case (aluOp)
      mipsPkg::aluSub: aluResult = opA - opB;
      mipsPkg::aluAnd: aluResult = opA & opB;
      mipsPkg::aluOr:  aluResult = opA | opB;
      // signed compare
      mipsPkg::aluSlt: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
      default:         aluResult = opA + opB;
    endcase
  end

  // beq uses this after sub
  assign aluZero = (aluResult == '0);

  // ========================================
  // data memory request
  // ========================================
  // chip enable only for lw and sw
  assign dmemReq.cen = !(ctrl.memRead || ctrl.memWrite);
  assign dmemReq.wen = !ctrl.memWrite;
  // word address from the byte address
  assign dmemReq.addr  = aluResult[8:2];
  // store data straight from rt
  assign dmemReq.wdata = rtData;

endmodule

`default_nettype wire

// ==== hdl/registerFile.sv ====
// ========================================
// registerFile
// 32x32 registers, r0 reads zero, two
// async reads and one write per edge;
// also builds the retire trace
// ========================================
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  wire                 clk,
  input  wire                 rst,
  input  wire mipsPkg::ctrl_t ctrl,
  input  wire mipsPkg::word_t instr,
  input  wire mipsPkg::word_t aluResult,
  input  wire mipsPkg::word_t dmemRdata,
  input  wire mipsPkg::word_t pcPlus4,
  output mipsPkg::word_t      rsData,
  output mipsPkg::word_t      rtData,
  output mipsPkg::retire_t    retire
);

  mipsPkg::word_t   regs [32];
  mipsPkg::regAddr_t rsAddr;
  mipsPkg::regAddr_t rtAddr;
  mipsPkg::regAddr_t rdAddr;
  mipsPkg::regAddr_t wrAddr;
  mipsPkg::word_t   wrData;
  logic             wrEn;

  // instruction fields
  assign rsAddr = instr[25:21];
  assign rtAddr = instr[20:16];
  assign rdAddr = instr[15:11];

  // ========================================
  // write port
  // ========================================
  always_comb begin
    if (ctrl.wbSel == mipsPkg::wbLink) begin
      wrAddr = mipsPkg::linkReg;
    end else if (ctrl.regDst) begin
      wrAddr = rdAddr;
    end else begin
      wrAddr = rtAddr;
    end
    case (ctrl.wbSel)
      mipsPkg::wbMem:  wrData = dmemRdata;
      mipsPkg::wbLink: wrData = pcPlus4;
      default:         wrData = aluResult;
    endcase
  end

  // writes to r0 are dropped
  assign wrEn = ctrl.regWrite && (wrAddr != '0);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // r0 is never written, so it stays zero
  assign rsData = regs[rsAddr];
  assign rtData = regs[rtAddr];

  // ========================================
  // trace
  // ========================================
  // regWrite here is the effective write
  // pc is filled in at the top
  assign retire.valid    = rst;
  assign retire.regWrite = wrEn;
  assign retire.regAddr  = wrAddr;
  assign retire.regData  = wrData;
  assign retire.pc       = '0;

endmodule

`default_nettype wire

// ==== hdl/pcUnit.sv ====
// ========================================
// pcUnit
// program counter register and next-pc
// select: sequential, branch, jump, jr
// ========================================
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
  input  wire                 clk,
  input  wire                 rst,
  input  wire mipsPkg::ctrl_t ctrl,
  input  wire mipsPkg::word_t instr,
  input  wire                 aluZero,
  input  wire mipsPkg::word_t rsData,
  output mipsPkg::word_t      pc,
  output mipsPkg::word_t      pcPlus4
);

  mipsPkg::word_t branchTarget;
  mipsPkg::word_t jumpTarget;
  mipsPkg::word_t nextPc;

  // ========================================
  // targets
  // ========================================
  assign pcPlus4 = pc + 32'd4;

  // sign-extended offset in words
  assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};

  // 256 MB region of pc+4
  assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

  always_comb begin
    case (ctrl.pcSel)
      // beq falls through when not equal
      mipsPkg::pcBranch: nextPc = (ctrl.branch && aluZero) ? branchTarget : pcPlus4;
      mipsPkg::pcJump:   nextPc = jumpTarget;
      // jr
      mipsPkg::pcReg:    nextPc = rsData;
      default:           nextPc = pcPlus4;
    endcase
  end

  // ========================================
  // pc register
  // ========================================
  // one instruction per edge
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= mipsPkg::resetPc;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/controlUnit.sv ====
// ========================================
// controlUnit
// decodes opcode and function into the
// control struct and the ALU operation
// ========================================
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  wire mipsPkg::word_t instr,
  output mipsPkg::ctrl_t      ctrl,
  output mipsPkg::aluOp_e     aluOp
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  // ========================================
  // decode
  // ========================================
  always_comb begin
    // defaults give a no-op
    // pc+4, no register or memory write
    ctrl.regWrite  = 1'b0;
    ctrl.regDst    = 1'b0;
    ctrl.aluSrcImm = 1'b0;
    ctrl.wbSel     = mipsPkg::wbAlu;
    ctrl.memRead   = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.branch    = 1'b0;
    ctrl.pcSel     = mipsPkg::pcSeq;
    aluOp          = mipsPkg::aluAdd;

    case (opcode)
      mipsPkg::opRtype: begin
        // r-type, operation chosen by funct
        ctrl.regDst = 1'b1;
        case (funct)
          mipsPkg::fnAdd: begin
            ctrl.regWrite = 1'b1;
            aluOp         = mipsPkg::aluAdd;
          end
          mipsPkg::fnSub: begin
            ctrl.regWrite = 1'b1;
            aluOp         = mipsPkg::aluSub;
          end
          mipsPkg::fnAnd: begin
            ctrl.regWrite = 1'b1;
            aluOp         = mipsPkg::aluAnd;
          end
          mipsPkg::fnOr: begin
            ctrl.regWrite = 1'b1;
            aluOp         = mipsPkg::aluOr;
          end
          mipsPkg::fnSlt: begin
            ctrl.regWrite = 1'b1;
            aluOp         = mipsPkg::aluSlt;
          end
          // jump to rs, no write
          mipsPkg::fnJr: ctrl.pcSel = mipsPkg::pcReg;
          // shifts etc. fall through as no-op
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      mipsPkg::opAddi: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      mipsPkg::opLw: begin
        // address = rs + imm, data back via wbMem
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.wbSel     = mipsPkg::wbMem;
        ctrl.memRead   = 1'b1;
      end
      mipsPkg::opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      mipsPkg::opBeq: begin
        // compare by subtraction, taken on zero
        ctrl.branch = 1'b1;
        ctrl.pcSel  = mipsPkg::pcBranch;
        aluOp       = mipsPkg::aluSub;
      end
      mipsPkg::opJ: ctrl.pcSel = mipsPkg::pcJump;
      mipsPkg::opJal: begin
        // link pc+4 into r31
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = mipsPkg::wbLink;
        ctrl.pcSel    = mipsPkg::pcJump;
      end
      default: ctrl.pcSel = mipsPkg::pcSeq;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/mipsPkg.sv ====
// ========================================
// mipsPkg
// shared widths, encodings, enums and the
// packed structs of the single-cycle core
// ========================================
`default_nettype none

package mipsPkg;

  // ========================================
  // widths
  // ========================================
  // data word and byte address
  typedef logic [31:0] word_t;
  // register index
  typedef logic [4:0] regAddr_t;
  // data memory word address, byte address bits 8..2
  typedef logic [6:0] memAddr_t;

  // ========================================
  // encodings
  // ========================================
  // primary opcodes, instr[31:26]
  localparam logic [5:0] opRtype = 6'b000000;
  localparam logic [5:0] opAddi  = 6'b001000;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opJal   = 6'b000011;

  // r-type function codes, instr[5:0]
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;
  localparam logic [5:0] fnJr  = 6'b001000;

  // jal link destination
  localparam regAddr_t linkReg = 5'd31;
  // first fetch address
  localparam word_t resetPc = 32'h0000_0000;

  // ========================================
  // enums
  // ========================================
  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_e;
  // write-back source
  typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSel_e;
  // next-pc source
  typedef enum logic [1:0] {pcSeq, pcBranch, pcJump, pcReg} pcSel_e;

  // ========================================
  // structs
  // ========================================
  // decoded control for one instruction
  typedef struct packed {
    logic   regWrite;
    logic   regDst;
    logic   aluSrcImm;
    wbSel_e wbSel;
    logic   memRead;
    logic   memWrite;
    logic   branch;
    pcSel_e pcSel;
  } ctrl_t;

  // sram request, cen and wen active low
  typedef struct packed {
    logic     cen;
    logic     wen;
    memAddr_t addr;
    word_t    wdata;
  } dmemReq_t;

  // trace of the instruction retiring at the next edge
  typedef struct packed {
    logic     valid;
    logic     regWrite;
    regAddr_t regAddr;
    word_t    regData;
    word_t    pc;
  } retire_t;

endpackage

`default_nettype wire
